// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - common/bp_pkg.sv
  - branch_predictor/pattern_table.sv
  - branch_predictor/branch_predictor.sv
  - source/fetch_frontend.sv
  - target: simulation
    files:
      - dv/branch_predictor_props.sv
      - dv/tb_fetch_frontend.sv

// File: branch_predictor/branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor #(
    parameter int index_bits = 6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  bp_pkg::pc_t if_pc,
    input  logic [31:0] if_instr,
    input  logic        id_branch_taken,
    input  bp_pkg::pc_t next_unpredicted_pc,
    output bp_pkg::pc_t next_pc,
    output logic        branch_prediction_failed,
    // second branch arrived while the first is resolving
    output logic        branch_consecutive_stall
);
    import bp_pkg::*;

    opcode_e    opcode;
    logic       is_branch;
    pc_t        b_imm;

    ctr_e       lookup_ctr;
    logic       predict_taken;

    // set for the cycle after a branch was fetched
    logic       in_flight_q;
    br_record_t record_q;

    logic       branch_fetch;
    logic       resolving;
    pc_t        recovery_pc;
    train_t     train_req;

    // decode
    assign opcode    = opcode_e'(if_instr[6:0]);
    assign is_branch = (opcode == opc_branch);

    // b-type immediate, bit 0 is always zero
    assign b_imm = {{51{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};

    pattern_table #(
        .index_bits(index_bits)
    ) pattern_table_i (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (if_pc),
        .lookup_ctr(lookup_ctr),
        .train     (train_req)
    );

    assign predict_taken = (lookup_ctr == weak_taken) || (lookup_ctr == strong_taken);

    // only predicted when nothing is pending, otherwise it is squashed or stalled
    assign branch_fetch = is_branch && !in_flight_q;

    // an in-flight branch resolves in the first unstalled cycle
    assign resolving = in_flight_q && !stall;

    assign branch_prediction_failed = resolving &&
                                      (record_q.predicted_taken != id_branch_taken);

    // hold the second branch one cycle when the first was right
    assign branch_consecutive_stall = resolving && !branch_prediction_failed && is_branch;

    // correct path of the resolved branch
    assign recovery_pc = id_branch_taken ? record_q.pc + record_q.offset
                                         : record_q.pc + 64'd4;

    always_comb begin
        if (branch_prediction_failed) begin
            next_pc = recovery_pc;
        end else if (branch_consecutive_stall) begin
            next_pc = if_pc;
        end else if (branch_fetch && predict_taken) begin
            next_pc = if_pc + b_imm;
        end else begin
            next_pc = next_unpredicted_pc;
        end
    end

    // train with the resolved direction
    assign train_req.valid = resolving;
    assign train_req.pc    = record_q.pc;
    assign train_req.taken = id_branch_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight_q <= 1'b0;
        end else if (!stall) begin
            // resolution always clears, a new branch is only taken when clear
            in_flight_q <= branch_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_fetch && !stall) begin
            record_q <= '{pc: if_pc, offset: b_imm, predicted_taken: predict_taken};
        end
    end

endmodule

// File: branch_predictor/pattern_table.sv
`timescale 1ns/10ps

module pattern_table #(
    parameter int index_bits = 6
) (
    input  logic           clk,
    input  logic           rst,
    input  bp_pkg::pc_t    lookup_pc,
    output bp_pkg::ctr_e   lookup_ctr,
    input  bp_pkg::train_t train
);
    import bp_pkg::*;

    localparam int entries = 1 << index_bits;

    ctr_e table_q [entries];

    // word-aligned pc, so bits 1:0 are dropped from the index
    logic [index_bits-1:0] lookup_idx;
    logic [index_bits-1:0] train_idx;

    ctr_e train_ctr;
    ctr_e train_ctr_next;

    assign lookup_idx = lookup_pc[index_bits+1:2];
    assign train_idx  = train.pc[index_bits+1:2];

    // read is combinational, prediction is made in the fetch cycle
    assign lookup_ctr = table_q[lookup_idx];

    // one step toward the resolved direction, holding at the strong states
    always_comb begin
        train_ctr = table_q[train_idx];
        unique case (train_ctr)
            strong_not_taken: train_ctr_next = train.taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   train_ctr_next = train.taken ? weak_taken : strong_not_taken;
            weak_taken:       train_ctr_next = train.taken ? strong_taken : weak_not_taken;
            strong_taken:     train_ctr_next = train.taken ? strong_taken : weak_taken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // all entries start weakly not taken
            for (int i = 0; i < entries; i++) begin
                table_q[i] <= weak_not_taken;
            end
        end else if (train.valid) begin
            table_q[train_idx] <= train_ctr_next;
        end
    end

endmodule

// File: common/bp_pkg.sv
package bp_pkg;

    // one fetch address, full xlen
    typedef logic [63:0] pc_t;

    // major opcode field, instr[6:0]
    // only branch is decoded by the predictor, the rest label test instructions
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_branch = 7'b1100011
    } opcode_e;

    // 2-bit saturating counter
    // msb set means predict taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_e;

    // branch held between prediction and resolution
    typedef struct packed {
        pc_t  pc;
        // sign-extended b-type offset
        pc_t  offset;
        logic predicted_taken;
    } br_record_t;

    // counter update sent to the pattern table
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
    } train_t;

endpackage

// File: dv/branch_predictor_props.sv
`timescale 1ns/10ps

module branch_predictor_props (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic in_flight,
    input logic failed,
    input logic consec_stall
);

    // at most one status pulse per cycle
    one_status: assert property (@(posedge clk) disable iff (rst)
        !(failed && consec_stall))
        else $error("failed and consecutive stall high in the same cycle");

    // stall freezes resolution
    quiet_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> (!failed && !consec_stall))
        else $error("status pulse while stall is high");

    fail_needs_branch: assert property (@(posedge clk) disable iff (rst)
        failed |-> in_flight)
        else $error("misprediction with no branch in flight");

    // resolution takes exactly one unstalled cycle
    resolve_once: assert property (@(posedge clk) disable iff (rst)
        (in_flight && !stall) |=> !in_flight)
        else $error("in-flight branch not cleared after resolving");

    reset_quiet: assert property (@(posedge clk)
        rst |=> (!failed && !consec_stall))
        else $error("status pulse in the cycle after reset");

endmodule

bind branch_predictor branch_predictor_props props_i (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .in_flight   (in_flight_q),
    .failed      (branch_prediction_failed),
    .consec_stall(branch_consecutive_stall)
);

// File: dv/fetch_cases.txt
// one line per cycle: instr word _ id_branch_taken _ stall
// branches are beq x0,x0: 00000863 +16, fe000ce3 -8, 02000063 +32, fe0008e3 -16
// straight line with one stall
00000013_0_0
00002083_0_0
002081b3_0_1
002081b3_0_0
00102023_0_0
// not taken, predicted not taken
00000863_0_0
00000013_0_0
00000013_0_0
// backward loop, first a miss, then trained taken
fe000ce3_0_0
00000013_1_0
00000013_0_0
00000013_0_0
fe000ce3_0_0
00000013_1_0
00000013_0_0
fe000ce3_0_0
00000013_1_0
00000013_0_0
fe000ce3_0_0
// loop exit, predicted taken but not taken
00000013_0_0
// forward miss
02000063_0_0
00000013_1_0
00000013_0_0
// two branches back to back
00000863_0_0
00000863_0_0
00000863_0_0
00000013_1_0
00000013_0_0
// stall before and during a branch in flight
00000863_0_1
00000863_0_0
00000013_1_1
00000013_1_1
00000013_1_0
00000013_0_0
// back to back with a stall in between
fe0008e3_0_0
fe0008e3_0_1
fe0008e3_0_0
fe0008e3_0_0
00000013_1_0
00000013_0_0
// miss squashes the branch behind it
00000863_0_0
00000863_1_0
00000013_0_0
// random taken and stall bits, seed 94
00000863_1_0
00000013_0_1
fe000ce3_1_0
fe000ce3_0_0
00000013_1_1
02000063_1_0
00000013_0_0
00002083_1_0
fe0008e3_0_1
fe0008e3_1_0
00000013_0_0
00102023_1_0
00000013_0_0

// File: dv/tb_fetch_frontend.sv
`timescale 1ns/10ps

module tb_fetch_frontend;
    import bp_pkg::*;

    localparam int          index_bits   = 6;
    localparam pc_t         reset_vector = 64'h0000_0000_8000_0000;
    // ns
    localparam int          clk_period   = 40;
    localparam int          reset_cycles = 8;
    localparam int          max_cases    = 256;
    localparam logic [6:0]  branch_major = 7'b1100011;

    logic        clk;
    logic        rst;
    logic        stall;
    logic [31:0] if_instr;
    logic        id_branch_taken;
    pc_t         if_pc;
    logic        branch_prediction_failed;
    logic        branch_consecutive_stall;

    // per cycle: instr in 39:8, taken nibble in 7:4, stall nibble in 3:0
    logic [39:0] cases [max_cases];
    int          num_cases;
    logic        cases_loaded;

    // reference model of the front end
    pc_t         model_pc;
    logic [1:0]  model_ctr [1 << index_bits];
    logic        model_in_flight;
    pc_t         model_rec_pc;
    pc_t         model_rec_offset;
    logic        model_rec_taken;

    fetch_frontend #(
        .index_bits  (index_bits),
        .reset_vector(reset_vector)
    ) dut_i (
        .clk                     (clk),
        .rst                     (rst),
        .stall                   (stall),
        .if_instr                (if_instr),
        .id_branch_taken         (id_branch_taken),
        .if_pc                   (if_pc),
        .branch_prediction_failed(branch_prediction_failed),
        .branch_consecutive_stall(branch_consecutive_stall)
    );

    always #(clk_period / 2) clk = ~clk;

    // b-type offset, imm[12|10:5] in 31:25 and imm[4:1|11] in 11:7
    function automatic pc_t offset_of(logic [31:0] instr);
        logic [12:0] imm;
        imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        return {{51{imm[12]}}, imm};
    endfunction

    function automatic int slot_of(pc_t pc);
        return int'(pc[index_bits+1:2]);
    endfunction

    // 0..3 counter, moves by one toward the outcome
    function automatic logic [1:0] count_toward(logic [1:0] ctr, logic taken);
        logic [1:0] result;
        if (taken) begin
            result = (ctr == 2'd3) ? 2'd3 : ctr + 2'd1;
        end else begin
            result = (ctr == 2'd0) ? 2'd0 : ctr - 2'd1;
        end
        return result;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one model cycle: flags from the current state, then the state after the edge
    task automatic step_model(input logic [31:0] instr, input logic taken,
                              input logic hold, output logic exp_failed,
                              output logic exp_consec);
        logic is_branch;
        logic guess;
        is_branch  = (instr[6:0] == branch_major);
        exp_failed = 1'b0;
        exp_consec = 1'b0;
        if (!hold) begin
            if (model_in_flight) begin
                // resolution, the word in fetch is never predicted here
                exp_failed = (model_rec_taken != taken);
                if (exp_failed) begin
                    if (taken) begin
                        model_pc = model_rec_pc + model_rec_offset;
                    end else begin
                        model_pc = model_rec_pc + 64'd4;
                    end
                end else if (is_branch) begin
                    // pc holds, branch is predicted next cycle
                    exp_consec = 1'b1;
                end else begin
                    model_pc = model_pc + 64'd4;
                end
                model_ctr[slot_of(model_rec_pc)] =
                    count_toward(model_ctr[slot_of(model_rec_pc)], taken);
                model_in_flight = 1'b0;
            end else if (is_branch) begin
                // upper counter bit is the prediction
                guess            = model_ctr[slot_of(model_pc)][1];
                model_rec_pc     = model_pc;
                model_rec_offset = offset_of(instr);
                model_rec_taken  = guess;
                model_in_flight  = 1'b1;
                model_pc         = guess ? model_pc + offset_of(instr) : model_pc + 64'd4;
            end else begin
                model_pc = model_pc + 64'd4;
            end
        end
    endtask

    initial begin
        logic exp_failed;
        logic exp_consec;
        clk             = 1'b0;
        rst             = 1'b1;
        stall           = 1'b0;
        if_instr        = 32'h0000_0013;
        id_branch_taken = 1'b0;
        cases_loaded    = 1'b0;

        // unread entries stay unknown and mark the end of the list
        for (int i = 0; i < max_cases; i++) begin
            cases[i] = 'x;
        end
        $readmemh("dv/fetch_cases.txt", cases);
        num_cases = 0;
        while (num_cases < max_cases && !$isunknown(cases[num_cases])) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("no cases could be read from dv/fetch_cases.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "empty case file");
        end
        cases_loaded = 1'b1;

        // model state after reset
        model_pc        = reset_vector;
        model_in_flight = 1'b0;
        for (int i = 0; i < (1 << index_bits); i++) begin
            model_ctr[i] = 2'd1;
        end

        repeat (reset_cycles) @(posedge clk);

        for (int i = 0; i < num_cases; i++) begin
            @(negedge clk);
            rst             = 1'b0;
            if_instr        = cases[i][39:8];
            id_branch_taken = cases[i][4];
            stall           = cases[i][0];
            // mid low phase, combinational outputs have settled
            #(clk_period / 4);
            compare("if_pc", model_pc, if_pc);
            step_model(if_instr, id_branch_taken, stall, exp_failed, exp_consec);
            compare("branch_prediction_failed", exp_failed, branch_prediction_failed);
            compare("branch_consecutive_stall", exp_consec, branch_consecutive_stall);
        end

        @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    // watchdog, sized from the case count plus reset and slack
    initial begin
        wait (cases_loaded);
        #((num_cases + 20) * clk_period);
        $display("watchdog: the %0d cases did not finish in time", num_cases);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: sim.f
common/bp_pkg.sv
branch_predictor/pattern_table.sv
branch_predictor/branch_predictor.sv
source/fetch_frontend.sv
dv/branch_predictor_props.sv
dv/tb_fetch_frontend.sv

// File: source/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend #(
    parameter int          index_bits   = 6,
    parameter bp_pkg::pc_t reset_vector = 64'h0000_0000_8000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    // word fetched at if_pc
    input  logic [31:0] if_instr,
    // outcome of the branch one cycle behind fetch
    input  logic        id_branch_taken,
    output bp_pkg::pc_t if_pc,
    output logic        branch_prediction_failed,
    output logic        branch_consecutive_stall
);
    import bp_pkg::*;

    pc_t next_pc;
    pc_t next_unpredicted_pc;

    // sequential fetch address
    assign next_unpredicted_pc = if_pc + 64'd4;

    // fetch pc register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_pc <= reset_vector;
        end else if (!stall) begin
            if_pc <= next_pc;
        end
    end

    // prediction, recovery and branch hazard handling
    branch_predictor #(
        .index_bits(index_bits)
    ) branch_predictor_i (
        .clk                     (clk),
        .rst                     (rst),
        .stall                   (stall),
        .if_pc                   (if_pc),
        .if_instr                (if_instr),
        .id_branch_taken         (id_branch_taken),
        .next_unpredicted_pc     (next_unpredicted_pc),
        .next_pc                 (next_pc),
        .branch_prediction_failed(branch_prediction_failed),
        .branch_consecutive_stall(branch_consecutive_stall)
    );

endmodule
